// File: sources.f
+incdir+rtl
+incdir+tb
rtl/rob_pkg.sv
rtl/rob_if.sv
rtl/rob_regfile.sv
rtl/rob_complete_table.sv
rtl/rob_ptr_ctrl.sv
rtl/rob_top.sv
tb/rob_tb.sv

// File: Makefile
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= rob_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/rob_tb_vectors.svh
task automatic load_steps();
    // tag, action, lane strobes, id0 (cdb id or source id), id1, lfsr word, dispatch pc,
    // then expected: ready, disp id0, disp id1, commit_valid,
    // commit pc0, word0, pc1, word1, source done
    add_step("reset", ACT_DISP,   'b11, 0, 0, 0, 'h100, 1, 0, 1, 'b00, 0, 0, 0, 0, 0);
    add_step("reset", ACT_DISP,   'b11, 0, 0, 0, 'h108, 1, 2, 3, 'b00, 0, 0, 0, 0, 0);
    add_step("fwd",   ACT_READ,   0,    1, 0, 0, 0,     1, 0, 0, 'b00, 0, 0, 0, 0, 0);
    add_step("order", ACT_CDB,    'b01, 1, 0, 0, 0,     1, 0, 0, 'b00, 0, 0, 0, 0, 0);
    add_step("fwd",   ACT_READ,   0,    1, 0, 0, 0,     1, 0, 0, 'b00, 0, 0, 0, 0, 1);
    add_step("order", ACT_CDB,    'b11, 0, 2, 1, 0,     1, 0, 0, 'b11, 'h100, 1, 'h104, 0, 0);
    add_step("order", ACT_COMMIT, 'b11, 0, 0, 0, 0,     1, 0, 0, 'b01, 'h108, 2, 0, 0, 0);
    add_step("order", ACT_COMMIT, 'b01, 0, 0, 0, 0,     1, 0, 0, 'b00, 0, 0, 0, 0, 0);

    // fill up to 15 entries, ids wrap after 15
    add_step("bp",    ACT_DISP,   'b11, 0, 0, 0, 'h200, 1, 4, 5, 'b00, 0, 0, 0, 0, 0);
    add_step("bp",    ACT_DISP,   'b11, 0, 0, 0, 'h208, 1, 6, 7, 'b00, 0, 0, 0, 0, 0);
    add_step("bp",    ACT_DISP,   'b11, 0, 0, 0, 'h210, 1, 8, 9, 'b00, 0, 0, 0, 0, 0);
    add_step("bp",    ACT_DISP,   'b11, 0, 0, 0, 'h218, 1, 10, 11, 'b00, 0, 0, 0, 0, 0);
    add_step("bp",    ACT_DISP,   'b11, 0, 0, 0, 'h220, 1, 12, 13, 'b00, 0, 0, 0, 0, 0);
    add_step("bp",    ACT_DISP,   'b11, 0, 0, 0, 'h228, 1, 14, 15, 'b00, 0, 0, 0, 0, 0);
    add_step("bp",    ACT_DISP,   'b11, 0, 0, 0, 'h230, 0, 0, 1, 'b00, 0, 0, 0, 0, 0);
    add_step("bp",    ACT_DISP,   'b11, 0, 0, 0, 'h300, 0, 2, 3, 'b00, 0, 0, 0, 0, 0);
    add_step("bp",    ACT_CDB,    'b11, 3, 4, 3, 0,     0, 0, 0, 'b11, 'h10c, 3, 'h200, 4, 0);
    add_step("bp",    ACT_COMMIT, 'b11, 0, 0, 0, 0,     1, 0, 0, 'b00, 0, 0, 0, 0, 0);
    add_step("bp",    ACT_DISP,   'b11, 0, 0, 0, 'h300, 0, 2, 3, 'b00, 0, 0, 0, 0, 0);
    add_step("bp",    ACT_READ,   0,    2, 0, 0, 0,     0, 0, 0, 'b00, 0, 0, 0, 0, 0);

    // complete id 0, then flush and reuse it
    add_step("flush", ACT_CDB,    'b01, 0, 0, 5, 0,     0, 0, 0, 'b00, 0, 0, 0, 0, 0);
    add_step("flush", ACT_READ,   0,    0, 0, 5, 0,     0, 0, 0, 'b00, 0, 0, 0, 0, 1);
    add_step("flush", ACT_FLUSH,  0,    0, 0, 0, 0,     1, 0, 0, 'b00, 0, 0, 0, 0, 0);
    add_step("flush", ACT_DISP,   'b01, 0, 0, 0, 'h400, 1, 0, 1, 'b00, 0, 0, 0, 0, 0);
    add_step("flush", ACT_READ,   0,    0, 0, 0, 0,     1, 0, 0, 'b00, 0, 0, 0, 0, 0);
    add_step("flush", ACT_DISP,   'b10, 0, 0, 0, 'h500, 1, 1, 1, 'b00, 0, 0, 0, 0, 0);
    add_step("flush", ACT_CDB,    'b11, 0, 1, 6, 0,     1, 0, 0, 'b11, 'h400, 6, 'h504, 7, 0);
    add_step("flush", ACT_COMMIT, 'b11, 0, 0, 0, 0,     1, 0, 0, 'b00, 0, 0, 0, 0, 0);
endtask

// File: tb/rob_tb.sv
`include "rob_defs.svh"

module rob_tb;

    typedef enum logic [2:0] {
        ACT_DISP,
        ACT_CDB,
        ACT_COMMIT,
        ACT_READ,
        ACT_FLUSH
    } act_e;

    // one row of the step table, unused columns stay zero
    typedef struct packed {
        act_e act;
        int   v, id0, id1, wd, pc;
        int   rdy, eid0, eid1, cv;
        int   pc0, wd0, pc1, wd1, done;
    } step_t;

    logic                                clk;
    logic                                rst_i;
    logic                                flush_i;
    logic [1:0]                          disp_valid_i;
    rob_pkg::rob_inst_entry_t [1:0]      disp_inst_i;
    rob_pkg::rob_id_t [1:0][1:0]         disp_src_id_i;
    logic                                disp_ready_o;
    rob_pkg::rob_id_t [1:0]              disp_id_o;
    rob_pkg::rob_data_entry_t [1:0][1:0] disp_src_data_o;
    logic [1:0][1:0]                     disp_src_done_o;
    logic [1:0]                          cdb_valid_i;
    rob_pkg::rob_id_t [1:0]              cdb_id_i;
    rob_pkg::rob_data_entry_t [1:0]      cdb_data_i;
    logic [1:0]                          commit_valid_o;
    rob_pkg::rob_inst_entry_t [1:0]      commit_inst_o;
    rob_pkg::rob_data_entry_t [1:0]      commit_data_o;
    logic [1:0]                          commit_req_i;

    step_t steps[$];
    string tags[$];
    int    cycles = 0;
    int    limit = 1000;

    rob_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // failure handling
    ////////////////////////////////////////////////////////////

    task automatic fail_stop(string why);
        $display("ERRORS FOUND");
        $fatal(1, "%s", why);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: the step table did not finish within %0d cycles", limit);
            fail_stop("simulation timed out");
        end
    end

    task automatic check_id(string name, rob_pkg::rob_id_t exp, rob_pkg::rob_id_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            fail_stop("rob id mismatch");
        end
    endtask

    task automatic check_inst(string name, rob_pkg::rob_inst_entry_t exp,
                              rob_pkg::rob_inst_entry_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            fail_stop("instruction entry mismatch");
        end
    endtask

    task automatic check_data(string name, rob_pkg::rob_data_entry_t exp,
                              rob_pkg::rob_data_entry_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            fail_stop("data entry mismatch");
        end
    endtask

    task automatic check_bits(string name, logic [1:0] exp, logic [1:0] act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            fail_stop("flag mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus values
    ////////////////////////////////////////////////////////////

    // word n is the (n+1)th group of 32 bits taken from the LFSR
    function automatic logic [`ROB_DATA_W-1:0] lfsr_word(int n);
        logic [31:0]            s;
        logic [`ROB_DATA_W-1:0] w;
        s = 32'h9cf9;
        w = '0;
        for (int b = 0; b < (n + 1) * `ROB_DATA_W; b++) begin
            w = {s[0], w[`ROB_DATA_W-1:1]};
            s = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
        end
        return w;
    endfunction

    // areg and opcode class follow from the pc
    function automatic rob_pkg::rob_inst_entry_t make_inst(int pc);
        rob_pkg::rob_inst_entry_t e;
        e.pc    = 32'(pc);
        e.areg  = e.pc[6:2];
        e.w_reg = 1'b1;
        e.op    = rob_pkg::rob_op_e'({1'b0, e.pc[3:2]});
        return e;
    endfunction

    function automatic rob_pkg::rob_data_entry_t make_data(int n);
        rob_pkg::rob_data_entry_t e;
        e.data = lfsr_word(n);
        e.exc  = e.data[0];
        return e;
    endfunction

    function automatic void add_step(string tag, act_e act, int v, int id0, int id1, int wd,
                                     int pc, int rdy, int eid0, int eid1, int cv, int pc0,
                                     int wd0, int pc1, int wd1, int done);
        steps.push_back('{act, v, id0, id1, wd, pc, rdy, eid0, eid1, cv, pc0, wd0, pc1, wd1,
                          done});
        tags.push_back(tag);
    endfunction

`include "rob_tb_vectors.svh"

    ////////////////////////////////////////////////////////////
    // drive and check
    ////////////////////////////////////////////////////////////

    task automatic drive_idle();
        flush_i      = 1'b0;
        disp_valid_i = '0;
        disp_inst_i  = '0;
        cdb_valid_i  = '0;
        cdb_id_i     = '0;
        cdb_data_i   = '0;
        commit_req_i = '0;
    endtask

    task automatic apply_step(step_t st);
        drive_idle();
        case (st.act)
            ACT_DISP: begin
                disp_valid_i   = 2'(st.v);
                disp_inst_i[0] = make_inst(st.pc);
                disp_inst_i[1] = make_inst(st.pc + 4);
            end
            ACT_CDB: begin
                cdb_valid_i   = 2'(st.v);
                cdb_id_i[0]   = rob_pkg::rob_id_t'(st.id0);
                cdb_id_i[1]   = rob_pkg::rob_id_t'(st.id1);
                cdb_data_i[0] = make_data(st.wd);
                cdb_data_i[1] = make_data(st.wd + 1);
            end
            ACT_COMMIT: commit_req_i = 2'(st.v);
            ACT_READ:   disp_src_id_i = {4{rob_pkg::rob_id_t'(st.id0)}};
            default:    flush_i = 1'b1;
        endcase
    endtask

    // ids are taken before the edge, everything else after it
    task automatic check_step(int i, step_t st, rob_pkg::rob_id_t [1:0] ids);
        string n;
        n = $sformatf("%s step %0d", tags[i], i);
        check_bits({n, " ready"}, {1'b0, 1'(st.rdy)}, {1'b0, disp_ready_o});
        check_bits({n, " commit_valid"}, 2'(st.cv), commit_valid_o);
        if (st.act == ACT_DISP) begin
            check_id({n, " disp id0"}, rob_pkg::rob_id_t'(st.eid0), ids[0]);
            check_id({n, " disp id1"}, rob_pkg::rob_id_t'(st.eid1), ids[1]);
        end
        if (st.cv[0]) begin
            check_inst({n, " commit inst0"}, make_inst(st.pc0), commit_inst_o[0]);
            check_data({n, " commit data0"}, make_data(st.wd0), commit_data_o[0]);
        end
        if (st.cv[1]) begin
            check_inst({n, " commit inst1"}, make_inst(st.pc1), commit_inst_o[1]);
            check_data({n, " commit data1"}, make_data(st.wd1), commit_data_o[1]);
        end
        // all four source ports read the same id
        if (st.act == ACT_READ) begin
            for (int l = 0; l < 2; l++) begin
                check_bits({n, $sformatf(" src done lane%0d", l)}, {2{1'(st.done)}},
                           disp_src_done_o[l]);
                if (st.done != 0) begin
                    check_data({n, $sformatf(" src data lane%0d a", l)}, make_data(st.wd),
                               disp_src_data_o[l][0]);
                    check_data({n, $sformatf(" src data lane%0d b", l)}, make_data(st.wd),
                               disp_src_data_o[l][1]);
                end
            end
        end
    endtask

    initial begin
        rob_pkg::rob_id_t [1:0] ids;
        drive_idle();
        disp_src_id_i = '0;
        rst_i = 1'b1;
        load_steps();
        limit = steps.size() * 4 + 20;
        repeat (4) @(negedge clk);
        rst_i = 1'b0;
        check_bits("reset ready", 2'b01, {1'b0, disp_ready_o});
        check_bits("reset commit_valid", 2'b00, commit_valid_o);
        foreach (steps[i]) begin
            apply_step(steps[i]);
            #1;
            ids = disp_id_o;
            @(negedge clk);
            drive_idle();
            check_step(i, steps[i], ids);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: rtl/rob_top.sv
module rob_top (
    input  logic                                clk,
    input  logic                                rst_i,
    input  logic                                flush_i,

    // dispatch lanes
    input  logic [1:0]                          disp_valid_i,
    input  rob_pkg::rob_inst_entry_t [1:0]      disp_inst_i,
    input  rob_pkg::rob_id_t [1:0][1:0]         disp_src_id_i,
    output logic                                disp_ready_o,
    output rob_pkg::rob_id_t [1:0]              disp_id_o,
    output rob_pkg::rob_data_entry_t [1:0][1:0] disp_src_data_o,
    output logic [1:0][1:0]                     disp_src_done_o,

    // CDB lanes
    input  logic [1:0]                          cdb_valid_i,
    input  rob_pkg::rob_id_t [1:0]              cdb_id_i,
    input  rob_pkg::rob_data_entry_t [1:0]      cdb_data_i,

    // commit lanes
    output logic [1:0]                          commit_valid_o,
    output rob_pkg::rob_inst_entry_t [1:0]      commit_inst_o,
    output rob_pkg::rob_data_entry_t [1:0]      commit_data_o,
    input  logic [1:0]                          commit_req_i
);

    logic [1:0]                        disp_we;
    // ports 5:4 read the tails, 3:0 the dispatch sources
    rob_pkg::rob_data_entry_t [5:0]    data_rd;

    rob_if cmt ();

    assign cmt.commit_req  = commit_req_i;
    assign commit_valid_o  = cmt.commit_valid;
    assign commit_data_o   = data_rd[5:4];
    assign disp_src_data_o = data_rd[3:0];

    ////////////////////////////////////////////////////////////
    // pointers and completion
    ////////////////////////////////////////////////////////////

    rob_ptr_ctrl u_ptr_ctrl (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .disp_valid_i (disp_valid_i),
        .disp_ready_o (disp_ready_o),
        .disp_id_o    (disp_id_o),
        .disp_we_o    (disp_we),
        .cmt          (cmt.ctrl)
    );

    rob_complete_table u_complete_table (
        .clk        (clk),
        .rst_i      (rst_i),
        .flush_i    (flush_i),
        .disp_we_i  (disp_we),
        .disp_id_i  (disp_id_o),
        .cdb_we_i   (cdb_valid_i),
        .cdb_id_i   (cdb_id_i),
        .src_id_i   (disp_src_id_i),
        .src_done_o (disp_src_done_o),
        .cmt        (cmt.tbl)
    );

    ////////////////////////////////////////////////////////////
    // entry tables
    ////////////////////////////////////////////////////////////

    // written at dispatch, read at the tails
    rob_regfile #(
        .DATA_W  ($bits(rob_pkg::rob_inst_entry_t)),
        .R_PORTS (2)
    ) inst_table (
        .clk     (clk),
        .raddr_i ({cmt.tail1, cmt.tail0}),
        .rdata_o (commit_inst_o),
        .waddr_i (disp_id_o),
        .we_i    (disp_we),
        .wdata_i (disp_inst_i)
    );

    // written by the CDB, read at the tails and for forwarding
    rob_regfile #(
        .DATA_W  ($bits(rob_pkg::rob_data_entry_t)),
        .R_PORTS (6)
    ) data_table (
        .clk     (clk),
        .raddr_i ({cmt.tail1, cmt.tail0, disp_src_id_i}),
        .rdata_o (data_rd),
        .waddr_i (cdb_id_i),
        .we_i    (cdb_valid_i),
        .wdata_i (cdb_data_i)
    );

endmodule

// File: rtl/rob_ptr_ctrl.sv
`include "rob_defs.svh"

module rob_ptr_ctrl (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   flush_i,

    // dispatch handshake
    input  logic [1:0]             disp_valid_i,
    output logic                   disp_ready_o,
    output rob_pkg::rob_id_t [1:0] disp_id_o,
    output logic [1:0]             disp_we_o,

    rob_if.ctrl                    cmt
);

    localparam int ID_W  = `ROB_ID_W;
    localparam int CNT_W = `ROB_ID_W + 1;
    // at least two free entries
    localparam logic [CNT_W-1:0] READY_MAX = CNT_W'(`ROB_DEPTH - 2);

    rob_pkg::rob_id_t head_q;
    rob_pkg::rob_id_t tail_q;
    logic [CNT_W-1:0] count_q;
    logic [1:0]       cmt_fire;
    logic [1:0]       n_disp;
    logic [1:0]       n_cmt;

    ////////////////////////////////////////////////////////////
    // allocation at the head
    ////////////////////////////////////////////////////////////

    assign disp_ready_o = (count_q <= READY_MAX);
    assign disp_we_o    = disp_valid_i & {2{disp_ready_o}};

    // lane 1 takes the next id only when lane 0 is used
    assign disp_id_o[0] = head_q;
    assign disp_id_o[1] = head_q + ID_W'(disp_valid_i[0]);

    assign n_disp = {1'b0, disp_we_o[0]} + {1'b0, disp_we_o[1]};

    ////////////////////////////////////////////////////////////
    // retire at the tail
    ////////////////////////////////////////////////////////////

    assign cmt.tail0 = tail_q;
    assign cmt.tail1 = tail_q + ID_W'(1);

    // stale complete bits beyond the count are masked
    assign cmt.commit_valid[0] = cmt.tail_done[0] & (count_q > CNT_W'(0));
    // program order, lane 1 is valid only behind a valid lane 0
    assign cmt.commit_valid[1] = cmt.tail_done[1] & (count_q > CNT_W'(1))
                                 & cmt.commit_valid[0];

    // lane 1 only retires behind lane 0
    assign cmt_fire[0] = cmt.commit_req[0] & cmt.commit_valid[0];
    assign cmt_fire[1] = cmt.commit_req[1] & cmt.commit_valid[1] & cmt_fire[0];

    assign n_cmt = {1'b0, cmt_fire[0]} + {1'b0, cmt_fire[1]};

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + ID_W'(n_disp);
            tail_q  <= tail_q + ID_W'(n_cmt);
            count_q <= count_q + CNT_W'(n_disp) - CNT_W'(n_cmt);
        end
    end

endmodule

// File: rtl/rob_complete_table.sv
`include "rob_defs.svh"

module rob_complete_table (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   flush_i,

    // dispatch writes
    input  logic [1:0]             disp_we_i,
    input  rob_pkg::rob_id_t [1:0] disp_id_i,

    // CDB writes
    input  logic [1:0]             cdb_we_i,
    input  rob_pkg::rob_id_t [1:0] cdb_id_i,

    // operand forwarding lookups
    input  rob_pkg::rob_id_t [3:0] src_id_i,
    output logic [3:0]             src_done_o,

    rob_if.tbl                     cmt
);

    // one bank per writer, complete = disp ^ cdb
    logic [`ROB_DEPTH-1:0] disp_bank_q;
    logic [`ROB_DEPTH-1:0] cdb_bank_q;
    logic [`ROB_DEPTH-1:0] done;

    assign done = disp_bank_q ^ cdb_bank_q;

    ////////////////////////////////////////////////////////////
    // bank updates
    ////////////////////////////////////////////////////////////

    // dispatch copies the cdb bit, entry becomes pending
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            disp_bank_q <= '0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (disp_we_i[k]) begin
                    disp_bank_q[disp_id_i[k]] <= cdb_bank_q[disp_id_i[k]];
                end
            end
        end
    end

    // cdb takes the inverse of the dispatch bit, entry becomes complete
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            cdb_bank_q <= '0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (cdb_we_i[k]) begin
                    cdb_bank_q[cdb_id_i[k]] <= ~disp_bank_q[cdb_id_i[k]];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // lookups
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int s = 0; s < 4; s++) begin
            src_done_o[s] = done[src_id_i[s]];
        end
    end

    assign cmt.tail_done[0] = done[cmt.tail0];
    assign cmt.tail_done[1] = done[cmt.tail1];

endmodule

// File: rtl/rob_regfile.sv
`include "rob_defs.svh"

module rob_regfile #(
    parameter int DATA_W  = 32,
    parameter int R_PORTS = 2
) (
    input  logic                           clk,

    // read side
    input  rob_pkg::rob_id_t [R_PORTS-1:0] raddr_i,
    output logic [R_PORTS-1:0][DATA_W-1:0] rdata_o,

    // write side, two lanes
    input  rob_pkg::rob_id_t [1:0]         waddr_i,
    input  logic [1:0]                     we_i,
    input  logic [1:0][DATA_W-1:0]         wdata_i
);

    logic [DATA_W-1:0] mem_q [`ROB_DEPTH];

    ////////////////////////////////////////////////////////////
    // write
    ////////////////////////////////////////////////////////////

    // lane 1 is applied last and wins on a shared address
    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            if (we_i[k]) begin
                mem_q[waddr_i[k]] <= wdata_i[k];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read
    ////////////////////////////////////////////////////////////

    // async read, same cycle as the address
    always_comb begin
        for (int p = 0; p < R_PORTS; p++) begin
            rdata_o[p] = mem_q[raddr_i[p]];
        end
    end

endmodule

// File: rtl/rob_if.sv
interface rob_if;

    // the two oldest entries
    rob_pkg::rob_id_t tail0;
    rob_pkg::rob_id_t tail1;

    // complete flags read at tail0 and tail1
    logic [1:0] tail_done;

    // retire handshake
    logic [1:0] commit_valid;
    logic [1:0] commit_req;

    // pointer control side
    modport ctrl (
        output tail0,
        output tail1,
        output commit_valid,
        input  tail_done,
        input  commit_req
    );

    // completion table side
    modport tbl (
        input  tail0,
        input  tail1,
        output tail_done
    );

endinterface

// File: rtl/rob_pkg.sv
`include "rob_defs.svh"

package rob_pkg;

    // index into the reorder buffer
    typedef logic [`ROB_ID_W-1:0] rob_id_t;

    // opcode class of a dispatched instruction
    // five classes need three bits
    typedef enum logic [2:0] {
        ROB_OP_ALU    = 3'd0,
        ROB_OP_MUL    = 3'd1,
        ROB_OP_LOAD   = 3'd2,
        ROB_OP_STORE  = 3'd3,
        ROB_OP_BRANCH = 3'd4
    } rob_op_e;

    ////////////////////////////////////////////////////////////
    // table entries
    ////////////////////////////////////////////////////////////

    // written once at dispatch
    typedef struct packed {
        logic [4:0]  areg;
        logic [31:0] pc;
        logic        w_reg;
        rob_op_e     op;
    } rob_inst_entry_t;

    // written by the CDB when the result arrives
    typedef struct packed {
        logic [`ROB_DATA_W-1:0] data;
        logic                   exc;
    } rob_data_entry_t;

endpackage

// File: rtl/rob_defs.svh
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// number of reorder buffer entries
`define ROB_DEPTH  16

// width of a rob id, log2 of the depth
`define ROB_ID_W   4

// result width carried on the CDB
`define ROB_DATA_W 32

`endif
